//--- rtl/csr_pkg.sv
package csr_pkg;

    // ------------------------------------------------------------------------
    // Basic types
    // ------------------------------------------------------------------------
    typedef logic [31:0] word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  cause_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    // mstatus, kept fields in their architectural positions
    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;
        logic [1:0]  rsvd_10_9;
        logic        spp;
        logic        mpie;
        logic        rsvd_6;
        logic        spie;
        logic        rsvd_4;
        logic        mie;
        logic        rsvd_2;
        logic        sie;
        logic        rsvd_0;
    } status_t;

    // One-cycle commit strobe of a CSR write
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        word_t     data;
    } csr_write_t;

    typedef struct packed {
        logic   valid;
        cause_t cause;
        word_t  pc;
        word_t  tval;
    } trap_req_t;

    // mret or sret, selected by level
    typedef struct packed {
        logic  valid;
        priv_t level;
    } xret_req_t;

    typedef struct packed {
        word_t  tvec;
        word_t  scratch;
        word_t  epc;
        cause_t cause;
        word_t  tval;
    } bank_regs_t;

    // Wishbone classic, master and slave halves
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        csr_addr_t adr;
        word_t     dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // ------------------------------------------------------------------------
    // CSR addresses
    // ------------------------------------------------------------------------
    localparam csr_addr_t ADDR_SSTATUS  = 12'h100;
    localparam csr_addr_t ADDR_STVEC    = 12'h105;
    localparam csr_addr_t ADDR_SSCRATCH = 12'h140;
    localparam csr_addr_t ADDR_SEPC     = 12'h141;
    localparam csr_addr_t ADDR_SCAUSE   = 12'h142;
    localparam csr_addr_t ADDR_STVAL    = 12'h143;

    localparam csr_addr_t ADDR_MSTATUS  = 12'h300;
    localparam csr_addr_t ADDR_MISA     = 12'h301;
    localparam csr_addr_t ADDR_MEDELEG  = 12'h302;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MTVAL    = 12'h343;

    localparam csr_addr_t ADDR_CYCLE    = 12'hc00;
    localparam csr_addr_t ADDR_TIME     = 12'hc01;
    localparam csr_addr_t ADDR_CYCLEH   = 12'hc80;
    localparam csr_addr_t ADDR_TIMEH    = 12'hc81;
    localparam csr_addr_t ADDR_MHARTID  = 12'hf14;

    // Register offsets inside one trap bank
    localparam csr_addr_t BANK_OFS_TVEC    = 12'h005;
    localparam csr_addr_t BANK_OFS_SCRATCH = 12'h000;
    localparam csr_addr_t BANK_OFS_EPC     = 12'h001;
    localparam csr_addr_t BANK_OFS_CAUSE   = 12'h002;
    localparam csr_addr_t BANK_OFS_TVAL    = 12'h003;

    // spp, spie and sie
    localparam word_t SSTATUS_MASK = 32'h0000_0122;

    // MXL=1, extensions I, S and U
    localparam word_t MISA_VALUE = 32'h4014_0100;

endpackage

//--- rtl/csr_access_port.sv
`timescale 1ns/100ps

module csr_access_port #(
    parameter csr_pkg::word_t HART_ID = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::wb_req_t     wb_req,
    input  csr_pkg::priv_t       priv,
    input  csr_pkg::status_t     status,
    input  csr_pkg::word_t       medeleg,
    input  csr_pkg::bank_regs_t  bank_m,
    input  csr_pkg::bank_regs_t  bank_s,
    output csr_pkg::wb_rsp_t     wb_rsp,
    output csr_pkg::csr_write_t  csr_write
);

    logic           ack_q;
    csr_pkg::word_t dat_q;
    csr_pkg::word_t rd_data;
    logic [63:0]    cycle_q;
    logic           req_new;

    // ------------------------------------------------------------------------
    // Wishbone classic slave
    // ------------------------------------------------------------------------

    // New request when strobed and not already acked
    assign req_new = wb_req.cyc && wb_req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new;
        end
    end

    // Read data sampled on the ack edge, old register values
    always_ff @(posedge clk) begin
        if (req_new) begin
            dat_q <= rd_data;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

    // Commit strobe, lands on the same edge as ack
    assign csr_write.en   = req_new && wb_req.we;
    assign csr_write.addr = wb_req.adr;
    assign csr_write.data = wb_req.dat;

    // Free-running cycle counter, also serves as time
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_q <= '0;
        end else begin
            cycle_q <= cycle_q + 64'd1;
        end
    end

    // ------------------------------------------------------------------------
    // Read multiplexer
    // ------------------------------------------------------------------------
    always_comb begin
        case (wb_req.adr)
            csr_pkg::ADDR_MSTATUS:  rd_data = status;
            csr_pkg::ADDR_SSTATUS:  rd_data = status & csr_pkg::SSTATUS_MASK;
            csr_pkg::ADDR_MEDELEG:  rd_data = medeleg;
            csr_pkg::ADDR_MISA:     rd_data = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MHARTID:  rd_data = HART_ID;

            csr_pkg::ADDR_MTVEC:    rd_data = bank_m.tvec;
            csr_pkg::ADDR_MSCRATCH: rd_data = bank_m.scratch;
            csr_pkg::ADDR_MEPC:     rd_data = bank_m.epc;
            csr_pkg::ADDR_MCAUSE:   rd_data = {28'h0, bank_m.cause};
            csr_pkg::ADDR_MTVAL:    rd_data = bank_m.tval;

            csr_pkg::ADDR_STVEC:    rd_data = bank_s.tvec;
            csr_pkg::ADDR_SSCRATCH: rd_data = bank_s.scratch;
            csr_pkg::ADDR_SEPC:     rd_data = bank_s.epc;
            csr_pkg::ADDR_SCAUSE:   rd_data = {28'h0, bank_s.cause};
            csr_pkg::ADDR_STVAL:    rd_data = bank_s.tval;

            csr_pkg::ADDR_CYCLE:    rd_data = cycle_q[31:0];
            csr_pkg::ADDR_TIME:     rd_data = cycle_q[31:0];
            csr_pkg::ADDR_CYCLEH:   rd_data = cycle_q[63:32];
            csr_pkg::ADDR_TIMEH:    rd_data = cycle_q[63:32];
            default:                rd_data = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Single-cycle ack, so one acknowledge per master request
    a_ack_single: assert property (@(posedge clk) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack);

    // Reads of privileged state only arrive once the hart has a legal level
    a_priv_legal: assert property (@(posedge clk) disable iff (rst)
        req_new |-> priv inside {csr_pkg::PRIV_U, csr_pkg::PRIV_S, csr_pkg::PRIV_M});

endmodule

//--- rtl/csr_trap_bank.sv
`timescale 1ns/100ps

module csr_trap_bank #(
    parameter csr_pkg::csr_addr_t SETUP_BASE  = 12'h300,
    parameter csr_pkg::csr_addr_t HANDLE_BASE = 12'h340
) (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::csr_write_t  csr_write,
    input  logic                 capture,
    input  csr_pkg::trap_req_t   trap,
    output csr_pkg::bank_regs_t  regs
);

    localparam csr_pkg::csr_addr_t ADDR_TVEC    = SETUP_BASE + csr_pkg::BANK_OFS_TVEC;
    localparam csr_pkg::csr_addr_t ADDR_SCRATCH = HANDLE_BASE + csr_pkg::BANK_OFS_SCRATCH;
    localparam csr_pkg::csr_addr_t ADDR_EPC     = HANDLE_BASE + csr_pkg::BANK_OFS_EPC;
    localparam csr_pkg::csr_addr_t ADDR_CAUSE   = HANDLE_BASE + csr_pkg::BANK_OFS_CAUSE;
    localparam csr_pkg::csr_addr_t ADDR_TVAL    = HANDLE_BASE + csr_pkg::BANK_OFS_TVAL;

    csr_pkg::bank_regs_t regs_q;

    // ------------------------------------------------------------------------
    // Register updates
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            regs_q <= '0;
        end else begin
            if (csr_write.en && csr_write.addr == ADDR_TVEC) begin
                regs_q.tvec <= csr_write.data;
            end
            if (csr_write.en && csr_write.addr == ADDR_SCRATCH) begin
                regs_q.scratch <= csr_write.data;
            end
            // Trap capture wins over a software write
            if (capture) begin
                regs_q.epc   <= trap.pc;
                regs_q.cause <= trap.cause;
                regs_q.tval  <= trap.tval;
            end else begin
                if (csr_write.en && csr_write.addr == ADDR_EPC) begin
                    regs_q.epc <= csr_write.data;
                end
                if (csr_write.en && csr_write.addr == ADDR_CAUSE) begin
                    regs_q.cause <= csr_write.data[3:0];
                end
                if (csr_write.en && csr_write.addr == ADDR_TVAL) begin
                    regs_q.tval <= csr_write.data;
                end
            end
        end
    end

    assign regs = regs_q;

    // Capture only follows a real exception request
    a_capture_on_trap: assert property (@(posedge clk) disable iff (rst)
        capture |-> trap.valid);

endmodule

//--- rtl/csr_trap_unit.sv
`timescale 1ns/100ps

module csr_trap_unit (
    input  logic                 clk,
    input  logic                 rst,
    input  csr_pkg::trap_req_t   trap,
    input  csr_pkg::xret_req_t   xret,
    input  csr_pkg::csr_write_t  csr_write,
    input  csr_pkg::bank_regs_t  bank_m,
    input  csr_pkg::bank_regs_t  bank_s,
    output csr_pkg::priv_t       priv,
    output csr_pkg::status_t     status,
    output csr_pkg::word_t       medeleg,
    output logic                 capture_m,
    output logic                 capture_s,
    output csr_pkg::word_t       redirect_pc
);

    csr_pkg::priv_t   priv_q;
    csr_pkg::priv_t   priv_d;
    csr_pkg::status_t status_q;
    csr_pkg::status_t status_d;
    csr_pkg::status_t wr_status;
    csr_pkg::word_t   medeleg_q;
    logic             to_s;
    logic             mret;
    logic             sret;

    // ------------------------------------------------------------------------
    // Trap target and redirect
    // ------------------------------------------------------------------------

    // Delegation never lowers a trap taken in machine mode
    assign to_s = medeleg_q[trap.cause] && (priv_q != csr_pkg::PRIV_M);

    assign capture_s = trap.valid && to_s;
    assign capture_m = trap.valid && !to_s;

    assign mret = xret.valid && (xret.level == csr_pkg::PRIV_M);
    assign sret = xret.valid && (xret.level == csr_pkg::PRIV_S);

    always_comb begin
        if (capture_s) begin
            redirect_pc = {bank_s.tvec[31:2], 2'b00};
        end else if (capture_m) begin
            redirect_pc = {bank_m.tvec[31:2], 2'b00};
        end else if (mret) begin
            redirect_pc = bank_m.epc;
        end else if (sret) begin
            redirect_pc = bank_s.epc;
        end else begin
            redirect_pc = '0;
        end
    end

    // ------------------------------------------------------------------------
    // Next privilege and status
    // ------------------------------------------------------------------------
    assign wr_status = csr_pkg::status_t'(csr_write.data);

    always_comb begin
        priv_d   = priv_q;
        status_d = status_q;
        if (capture_s) begin
            status_d.spp  = priv_q[0];
            status_d.spie = status_q.sie;
            status_d.sie  = 1'b0;
            priv_d        = csr_pkg::PRIV_S;
        end else if (capture_m) begin
            status_d.mpp  = priv_q;
            status_d.mpie = status_q.mie;
            status_d.mie  = 1'b0;
            priv_d        = csr_pkg::PRIV_M;
        end else if (mret) begin
            priv_d        = csr_pkg::priv_t'(status_q.mpp);
            status_d.mie  = status_q.mpie;
            status_d.mpie = 1'b1;
            status_d.mpp  = csr_pkg::PRIV_U;
        end else if (sret) begin
            priv_d        = status_q.spp ? csr_pkg::PRIV_S : csr_pkg::PRIV_U;
            status_d.sie  = status_q.spie;
            status_d.spie = 1'b1;
            status_d.spp  = 1'b0;
        end else if (csr_write.en && csr_write.addr == csr_pkg::ADDR_MSTATUS) begin
            // Reserved bits stay zero
            status_d      = '0;
            status_d.mpp  = wr_status.mpp;
            status_d.spp  = wr_status.spp;
            status_d.mpie = wr_status.mpie;
            status_d.spie = wr_status.spie;
            status_d.mie  = wr_status.mie;
            status_d.sie  = wr_status.sie;
        end else if (csr_write.en && csr_write.addr == csr_pkg::ADDR_SSTATUS) begin
            status_d = csr_pkg::status_t'((status_q & ~csr_pkg::SSTATUS_MASK)
                                          | (csr_write.data & csr_pkg::SSTATUS_MASK));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv_q    <= csr_pkg::PRIV_M;
            status_q  <= '0;
            medeleg_q <= '0;
        end else begin
            priv_q   <= priv_d;
            status_q <= status_d;
            if (csr_write.en && csr_write.addr == csr_pkg::ADDR_MEDELEG) begin
                medeleg_q <= csr_write.data;
            end
        end
    end

    assign priv    = priv_q;
    assign status  = status_q;
    assign medeleg = medeleg_q;

    // Trap and trap return come from different pipeline events
    a_trap_xret_excl: assert property (@(posedge clk) disable iff (rst)
        !(trap.valid && xret.valid));

endmodule

//--- rtl/csr_top.sv
`timescale 1ns/100ps

module csr_top #(
    parameter csr_pkg::word_t     HART_ID       = 32'h0000_0000,
    parameter csr_pkg::csr_addr_t M_SETUP_BASE  = 12'h300,
    parameter csr_pkg::csr_addr_t M_HANDLE_BASE = 12'h340,
    parameter csr_pkg::csr_addr_t S_SETUP_BASE  = 12'h100,
    parameter csr_pkg::csr_addr_t S_HANDLE_BASE = 12'h140
) (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::wb_req_t    wb_req,
    input  csr_pkg::trap_req_t  trap,
    input  csr_pkg::xret_req_t  xret,
    output csr_pkg::wb_rsp_t    wb_rsp,
    output csr_pkg::priv_t      priv,
    output csr_pkg::status_t    status,
    output csr_pkg::word_t      redirect_pc
);

    csr_pkg::csr_write_t csr_write;
    csr_pkg::word_t      medeleg;
    csr_pkg::bank_regs_t bank_m;
    csr_pkg::bank_regs_t bank_s;
    logic                capture_m;
    logic                capture_s;

    // ------------------------------------------------------------------------
    // CSR access over Wishbone
    // ------------------------------------------------------------------------
    csr_access_port #(
        .HART_ID (HART_ID)
    ) u_access_port (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .priv      (priv),
        .status    (status),
        .medeleg   (medeleg),
        .bank_m    (bank_m),
        .bank_s    (bank_s),
        .wb_rsp    (wb_rsp),
        .csr_write (csr_write)
    );

    // ------------------------------------------------------------------------
    // Privilege, status and trap control
    // ------------------------------------------------------------------------
    csr_trap_unit u_trap_unit (
        .clk         (clk),
        .rst         (rst),
        .trap        (trap),
        .xret        (xret),
        .csr_write   (csr_write),
        .bank_m      (bank_m),
        .bank_s      (bank_s),
        .priv        (priv),
        .status      (status),
        .medeleg     (medeleg),
        .capture_m   (capture_m),
        .capture_s   (capture_s),
        .redirect_pc (redirect_pc)
    );

    // Machine and supervisor trap banks
    csr_trap_bank #(
        .SETUP_BASE  (M_SETUP_BASE),
        .HANDLE_BASE (M_HANDLE_BASE)
    ) u_bank_m (
        .clk       (clk),
        .rst       (rst),
        .csr_write (csr_write),
        .capture   (capture_m),
        .trap      (trap),
        .regs      (bank_m)
    );

    csr_trap_bank #(
        .SETUP_BASE  (S_SETUP_BASE),
        .HANDLE_BASE (S_HANDLE_BASE)
    ) u_bank_s (
        .clk       (clk),
        .rst       (rst),
        .csr_write (csr_write),
        .capture   (capture_s),
        .trap      (trap),
        .regs      (bank_s)
    );

endmodule

//--- tb/csr_tb.sv
`timescale 1ns/100ps

module csr_tb;

    localparam int                 CLK_PERIOD   = 20;
    localparam int                 DRIVE_SKEW   = 2;
    localparam int                 SEED         = 23453;
    localparam int                 NUM_PHASES   = 6;
    localparam int                 PHASE_CYCLES = 400;
    localparam int                 ACK_LIMIT    = 10;
    localparam int                 CYCLE_GAP    = 50;
    localparam csr_pkg::word_t     HART_ID      = 32'h0000_0005;
    localparam csr_pkg::csr_addr_t UNMAPPED     = 12'h7c0;
    // mpp, spp, mpie, spie, mie and sie
    localparam csr_pkg::word_t     STATUS_KEPT  = 32'h0000_19aa;
    localparam int                 NUM_RW       = 11;
    localparam csr_pkg::csr_addr_t RW_ADDRS [NUM_RW] = '{
        csr_pkg::ADDR_MTVEC, csr_pkg::ADDR_MSCRATCH, csr_pkg::ADDR_MEPC,
        csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MTVAL, csr_pkg::ADDR_STVEC,
        csr_pkg::ADDR_SSCRATCH, csr_pkg::ADDR_SEPC, csr_pkg::ADDR_SCAUSE,
        csr_pkg::ADDR_STVAL, csr_pkg::ADDR_MEDELEG
    };

    logic                clk;
    logic                rst;
    csr_pkg::wb_req_t    wb_req;
    csr_pkg::trap_req_t  trap;
    csr_pkg::xret_req_t  xret;
    csr_pkg::wb_rsp_t    wb_rsp;
    csr_pkg::priv_t      priv;
    csr_pkg::status_t    status;
    csr_pkg::word_t      redirect_pc;

    // Shadow model of the architectural state
    csr_pkg::priv_t      m_priv;
    csr_pkg::status_t    m_status;
    csr_pkg::word_t      m_medeleg;
    csr_pkg::bank_regs_t m_bank_m;
    csr_pkg::bank_regs_t m_bank_s;
    logic                model_on;

    csr_top #(
        .HART_ID (HART_ID)
    ) i_csr_top (
        .clk         (clk),
        .rst         (rst),
        .wb_req      (wb_req),
        .trap        (trap),
        .xret        (xret),
        .wb_rsp      (wb_rsp),
        .priv        (priv),
        .status      (status),
        .redirect_pc (redirect_pc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Error reporting and compare tasks
    // ------------------------------------------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input csr_pkg::word_t got,
                              input csr_pkg::word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    task automatic check_priv(input string name, input csr_pkg::priv_t got,
                              input csr_pkg::priv_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t: %s got %0d (%s) expected %0d (%s)",
                               $time, name, got, got.name(), exp, exp.name()));
        end
    endtask

    task automatic check_status(input string name, input csr_pkg::status_t got,
                                input csr_pkg::status_t exp);
        if (got !== exp) begin
            stop_run($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, name, got, exp));
        end
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic csr_pkg::word_t ref_read(input csr_pkg::csr_addr_t addr);
        case (addr)
            csr_pkg::ADDR_MSTATUS:  return csr_pkg::word_t'(m_status);
            csr_pkg::ADDR_SSTATUS:  return csr_pkg::word_t'(m_status) & csr_pkg::SSTATUS_MASK;
            csr_pkg::ADDR_MEDELEG:  return m_medeleg;
            csr_pkg::ADDR_MISA:     return csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MHARTID:  return HART_ID;
            csr_pkg::ADDR_MTVEC:    return m_bank_m.tvec;
            csr_pkg::ADDR_MSCRATCH: return m_bank_m.scratch;
            csr_pkg::ADDR_MEPC:     return m_bank_m.epc;
            csr_pkg::ADDR_MCAUSE:   return {28'h0, m_bank_m.cause};
            csr_pkg::ADDR_MTVAL:    return m_bank_m.tval;
            csr_pkg::ADDR_STVEC:    return m_bank_s.tvec;
            csr_pkg::ADDR_SSCRATCH: return m_bank_s.scratch;
            csr_pkg::ADDR_SEPC:     return m_bank_s.epc;
            csr_pkg::ADDR_SCAUSE:   return {28'h0, m_bank_s.cause};
            csr_pkg::ADDR_STVAL:    return m_bank_s.tval;
            default:                return 32'h0;
        endcase
    endfunction

    function automatic void model_write(input csr_pkg::csr_addr_t addr,
                                        input csr_pkg::word_t data);
        case (addr)
            csr_pkg::ADDR_MSTATUS:  m_status = csr_pkg::status_t'(data & STATUS_KEPT);
            csr_pkg::ADDR_SSTATUS:  m_status = csr_pkg::status_t'(
                (csr_pkg::word_t'(m_status) & ~csr_pkg::SSTATUS_MASK)
                | (data & csr_pkg::SSTATUS_MASK));
            csr_pkg::ADDR_MEDELEG:  m_medeleg = data;
            csr_pkg::ADDR_MTVEC:    m_bank_m.tvec = data;
            csr_pkg::ADDR_MSCRATCH: m_bank_m.scratch = data;
            csr_pkg::ADDR_MEPC:     m_bank_m.epc = data;
            csr_pkg::ADDR_MCAUSE:   m_bank_m.cause = data[3:0];
            csr_pkg::ADDR_MTVAL:    m_bank_m.tval = data;
            csr_pkg::ADDR_STVEC:    m_bank_s.tvec = data;
            csr_pkg::ADDR_SSCRATCH: m_bank_s.scratch = data;
            csr_pkg::ADDR_SEPC:     m_bank_s.epc = data;
            csr_pkg::ADDR_SCAUSE:   m_bank_s.cause = data[3:0];
            csr_pkg::ADDR_STVAL:    m_bank_s.tval = data;
            default:                ;
        endcase
    endfunction

    // Delegation only applies below machine mode
    function automatic logic goes_to_s(input csr_pkg::cause_t cause);
        return m_medeleg[cause] && (m_priv != csr_pkg::PRIV_M);
    endfunction

    function automatic void model_trap(input csr_pkg::cause_t cause,
                                       input csr_pkg::word_t pc, input csr_pkg::word_t tval);
        if (goes_to_s(cause)) begin
            m_status.spp   = (m_priv == csr_pkg::PRIV_S);
            m_status.spie  = m_status.sie;
            m_status.sie   = 1'b0;
            m_priv         = csr_pkg::PRIV_S;
            m_bank_s.epc   = pc;
            m_bank_s.cause = cause;
            m_bank_s.tval  = tval;
        end else begin
            m_status.mpp   = m_priv;
            m_status.mpie  = m_status.mie;
            m_status.mie   = 1'b0;
            m_priv         = csr_pkg::PRIV_M;
            m_bank_m.epc   = pc;
            m_bank_m.cause = cause;
            m_bank_m.tval  = tval;
        end
    endfunction

    function automatic void model_xret(input csr_pkg::priv_t level);
        if (level == csr_pkg::PRIV_M) begin
            m_priv        = csr_pkg::priv_t'(m_status.mpp);
            m_status.mie  = m_status.mpie;
            m_status.mpie = 1'b1;
            m_status.mpp  = csr_pkg::PRIV_U;
        end else begin
            m_priv        = m_status.spp ? csr_pkg::PRIV_S : csr_pkg::PRIV_U;
            m_status.sie  = m_status.spie;
            m_status.spie = 1'b1;
            m_status.spp  = 1'b0;
        end
    endfunction

    // Privilege and status outputs against the model at mid-cycle
    always @(negedge clk) begin
        if (model_on) begin
            check_priv("priv", priv, m_priv);
            check_status("status", status, m_status);
        end
    end

    // ------------------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------------------
    task automatic wb_access(input logic we, input csr_pkg::csr_addr_t addr,
                             input csr_pkg::word_t data, output csr_pkg::word_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        #DRIVE_SKEW;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = addr;
        wb_req.dat = data;
        if (wb_rsp.ack) begin
            stop_run($sformatf("ack already high when the request for address %h started",
                               addr));
        end
        do begin
            @(posedge clk);
            #DRIVE_SKEW;
            waited++;
            if (waited > ACK_LIMIT) begin
                stop_run($sformatf("no ack from the CSR port within %0d cycles, address %h",
                                   ACK_LIMIT, addr));
            end
        end while (!wb_rsp.ack);
        rdata      = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        if (waited != 1) begin
            stop_run($sformatf("ack for address %h came %0d cycles after the request, not 1",
                               addr, waited));
        end
        if (we) begin
            model_write(addr, data);
        end
    endtask

    task automatic wb_write(input csr_pkg::csr_addr_t addr, input csr_pkg::word_t data);
        csr_pkg::word_t unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input csr_pkg::csr_addr_t addr, output csr_pkg::word_t data);
        wb_access(1'b0, addr, 32'h0, data);
    endtask

    task automatic read_check(input csr_pkg::csr_addr_t addr);
        csr_pkg::word_t val;
        wb_read(addr, val);
        check_word($sformatf("csr 0x%h", addr), val, ref_read(addr));
    endtask

    task automatic check_regs();
        for (int i = 0; i < NUM_RW; i++) begin
            read_check(RW_ADDRS[i]);
        end
        read_check(csr_pkg::ADDR_MSTATUS);
        read_check(csr_pkg::ADDR_SSTATUS);
    endtask

    task automatic do_trap(input csr_pkg::cause_t cause, input csr_pkg::word_t pc,
                           input csr_pkg::word_t tval);
        csr_pkg::word_t exp_pc;
        exp_pc = (goes_to_s(cause) ? m_bank_s.tvec : m_bank_m.tvec) & ~32'h3;
        @(posedge clk);
        #DRIVE_SKEW;
        trap.valid = 1'b1;
        trap.cause = cause;
        trap.pc    = pc;
        trap.tval  = tval;
        @(negedge clk);
        check_word("redirect_pc", redirect_pc, exp_pc);
        @(posedge clk);
        #DRIVE_SKEW;
        trap.valid = 1'b0;
        model_trap(cause, pc, tval);
        #1;
        check_word("redirect_pc", redirect_pc, 32'h0);
    endtask

    task automatic do_xret(input csr_pkg::priv_t level);
        csr_pkg::word_t exp_pc;
        exp_pc = (level == csr_pkg::PRIV_M) ? m_bank_m.epc : m_bank_s.epc;
        @(posedge clk);
        #DRIVE_SKEW;
        xret.valid = 1'b1;
        xret.level = level;
        @(negedge clk);
        check_word("redirect_pc", redirect_pc, exp_pc);
        @(posedge clk);
        #DRIVE_SKEW;
        xret.valid = 1'b0;
        model_xret(level);
        #1;
        check_word("redirect_pc", redirect_pc, 32'h0);
    endtask

    // Watchdog sized from the phase count
    initial begin
        #(NUM_PHASES * PHASE_CYCLES * CLK_PERIOD);
        stop_run($sformatf("watchdog expired, run did not finish in %0d cycles",
                           NUM_PHASES * PHASE_CYCLES));
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        csr_pkg::word_t  c0;
        csr_pkg::word_t  c1;
        csr_pkg::cause_t dc;

        void'($urandom(SEED));
        clk       = 1'b0;
        rst       = 1'b1;
        wb_req    = '0;
        trap      = '0;
        xret      = '0;
        model_on  = 1'b0;
        m_priv    = csr_pkg::PRIV_M;
        m_status  = '0;
        m_medeleg = '0;
        m_bank_m  = '0;
        m_bank_s  = '0;
        repeat (2) @(posedge clk);
        #DRIVE_SKEW;
        rst      = 1'b0;
        model_on = 1'b1;

        // Phase 1 checks reset values and read-only registers
        @(negedge clk);
        check_word("redirect_pc", redirect_pc, 32'h0);
        read_check(csr_pkg::ADDR_MISA);
        read_check(csr_pkg::ADDR_MHARTID);
        check_regs();

        // Phase 2 writes random data to every bank register and medeleg
        repeat (3) begin
            for (int i = 0; i < NUM_RW; i++) begin
                wb_write(RW_ADDRS[i], $urandom);
            end
            check_regs();
        end
        wb_write(UNMAPPED, $urandom);
        read_check(UNMAPPED);
        check_regs();

        // Phase 3 covers sstatus as a masked view of mstatus
        repeat (4) begin
            wb_write(csr_pkg::ADDR_MSTATUS, $urandom);
            read_check(csr_pkg::ADDR_MSTATUS);
            wb_write(csr_pkg::ADDR_SSTATUS, $urandom);
            read_check(csr_pkg::ADDR_MSTATUS);
            read_check(csr_pkg::ADDR_SSTATUS);
        end
        wb_write(csr_pkg::ADDR_MSTATUS, 32'h0);

        // Phase 4 traps into machine mode and returns with mret
        wb_write(csr_pkg::ADDR_MTVEC, $urandom);
        wb_write(csr_pkg::ADDR_MSTATUS, 32'h0000_0008);
        do_trap(csr_pkg::cause_t'($urandom), $urandom, $urandom);
        check_regs();
        do_xret(csr_pkg::PRIV_M);
        wb_write(csr_pkg::ADDR_MSTATUS, 32'h0000_0800);
        wb_write(csr_pkg::ADDR_MEPC, $urandom);
        do_xret(csr_pkg::PRIV_M);
        wb_write(csr_pkg::ADDR_MEDELEG, 32'h0);
        do_trap(csr_pkg::cause_t'($urandom), $urandom, $urandom);
        check_regs();
        do_xret(csr_pkg::PRIV_M);

        // Phase 5 delegates traps from supervisor and user mode
        dc = csr_pkg::cause_t'($urandom);
        wb_write(csr_pkg::ADDR_MEDELEG, $urandom | (32'h1 << dc));
        wb_write(csr_pkg::ADDR_STVEC, $urandom);
        wb_write(csr_pkg::ADDR_SSTATUS, 32'h0000_0002);
        do_trap(dc, $urandom, $urandom);
        check_regs();
        do_xret(csr_pkg::PRIV_S);
        wb_write(csr_pkg::ADDR_SSTATUS, 32'h0);
        do_xret(csr_pkg::PRIV_S);
        do_trap(dc, $urandom, $urandom);
        check_regs();
        do_xret(csr_pkg::PRIV_S);
        wb_write(csr_pkg::ADDR_MEDELEG, ~(32'h1 << dc));
        do_trap(dc, $urandom, $urandom);
        wb_write(csr_pkg::ADDR_MEDELEG, 32'h1 << dc);
        do_trap(dc, $urandom, $urandom);
        check_regs();

        // Phase 6 checks that the cycle counter advances
        wb_read(csr_pkg::ADDR_CYCLE, c0);
        repeat (CYCLE_GAP) @(posedge clk);
        wb_read(csr_pkg::ADDR_CYCLE, c1);
        if (c1 - c0 < CYCLE_GAP) begin
            stop_run($sformatf("cycle counter moved by %0d over at least %0d cycles",
                               c1 - c0, CYCLE_GAP));
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- files.f
rtl/csr_pkg.sv
rtl/csr_access_port.sv
rtl/csr_trap_bank.sv
rtl/csr_trap_unit.sv
rtl/csr_top.sv
tb/csr_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= csr_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' files.f)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) files.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f files.f

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^Test passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
